//--- compile.f
spi_bridge_proto_pkg.sv
spi_bridge_cfg_pkg.sv
spi_edge_sync.sv
spi_bit_counter.sv
spi_dir_fsm.sv
spi_sdio_ctrl.sv
spi_bridge_top.sv
tb_spi_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Builds the SPI bridge testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f compile.f \
  --top-module tb_spi_bridge \
  -o sim_tb_spi_bridge

out=$(./obj_dir/sim_tb_spi_bridge)
echo "$out"

if echo "$out" | grep -qF -- '*** TEST PASSED ***'; then
  exit 0
else
  exit 1
fi

//--- tb_spi_bridge.sv
// ************************************************
// Testbench for the SPI bridge: host and device models, checks
// ************************************************

`timescale 1ns/10ps
`default_nettype none

module tb_spi_bridge;

  // SCLK half period in clk_i cycles, and the gap between frames
  localparam int HALF_CLKS   = 8;
  localparam int IDLE_CLKS   = 16;
  localparam int WATCHDOG_NS = 2000000;

  logic                                  clk_i;
  logic                                  rst_n_i;
  logic                                  spi_clk_i;
  logic [spi_bridge_cfg_pkg::NUM_CS-1:0] spi_csn_i;
  logic                                  spi_mosi_i;
  logic                                  sdio_i;
  logic                                  spi_miso_o;
  logic                                  sdio_o;
  logic                                  sdio_oe_o;
  logic                                  conv_csn_o;
  logic                                  synth_csn_o;

  // Frame bookkeeping kept by the host model for the checks
  logic        rd_frame;
  logic        drive_frame;
  logic        rd_data_win;
  int          host_rise_cnt;
  logic [1:0]  mosi_hist;
  logic [1:0]  sdio_hist;
  logic [31:0] lfsr_q;
  int          err_cnt;
  int          test_cnt;
  int          test_err_base;
  string       cur_test;

  spi_bridge_top dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .spi_clk_i   (spi_clk_i),
    .spi_csn_i   (spi_csn_i),
    .spi_mosi_i  (spi_mosi_i),
    .sdio_i      (sdio_i),
    .spi_miso_o  (spi_miso_o),
    .sdio_o      (sdio_o),
    .sdio_oe_o   (sdio_oe_o),
    .conv_csn_o  (conv_csn_o),
    .synth_csn_o (synth_csn_o));

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Two-deep history of the pins, index 1 is the value two cycles back
  always_ff @(posedge clk_i) begin
    mosi_hist <= {mosi_hist[0], spi_mosi_i};
    sdio_hist <= {sdio_hist[0], sdio_i};
  end

  // ************************************************
  // Checks
  // ************************************************

  reset_state_a : assert property (@(posedge clk_i) $rose(rst_n_i) |-> sdio_oe_o && !spi_miso_o)
    else begin
      err_cnt++;
      $display("[FAIL] %s reset_state expected oe=1 miso=0 actual oe=%b miso=%b",
               cur_test, $sampled(sdio_oe_o), $sampled(spi_miso_o));
    end

  // MOSI reaches the pin through the two synchronizer stages
  mosi_to_pin_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sdio_o == mosi_hist[1])
    else begin
      err_cnt++;
      $display("[FAIL] %s mosi_to_pin expected %b actual %b",
               cur_test, $sampled(mosi_hist[1]), $sampled(sdio_o));
    end

  // Write frames and synthesizer frames never give the pin away
  pin_kept_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    drive_frame |-> sdio_oe_o && !spi_miso_o)
    else begin
      err_cnt++;
      $display("[FAIL] %s pin_kept expected oe=1 miso=0 actual oe=%b miso=%b",
               cur_test, $sampled(sdio_oe_o), $sampled(spi_miso_o));
    end

  // Turnaround lands 6 cycles after the SCLK fall behind the last instruction bit
  turnaround_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ($past(spi_clk_i, 7) && !$past(spi_clk_i, 6) && $past(rd_frame, 6) &&
     ($past(host_rise_cnt, 6) == int'(spi_bridge_proto_pkg::INSTR_BITS)))
    |-> !sdio_oe_o && $past(sdio_oe_o))
    else begin
      err_cnt++;
      $display("[FAIL] %s turnaround expected oe=0 after 6 cycles actual oe=%b",
               cur_test, $sampled(sdio_oe_o));
    end

  read_data_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_data_win && !sdio_oe_o |-> spi_miso_o == sdio_hist[1])
    else begin
      err_cnt++;
      $display("[FAIL] %s read_data expected %b actual %b",
               cur_test, $sampled(sdio_hist[1]), $sampled(spi_miso_o));
    end

  // The pin comes back 5 cycles after the converter select rises on a read
  pin_return_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ($past(rd_frame, 5) && $past(spi_csn_i[0], 5) && !$past(spi_csn_i[0], 6))
    |-> sdio_oe_o && !$past(sdio_oe_o))
    else begin
      err_cnt++;
      $display("[FAIL] %s pin_return expected oe=1 after 5 cycles actual oe=%b",
               cur_test, $sampled(sdio_oe_o));
    end

  cs_pass_a : assert property (@(posedge clk_i)
    conv_csn_o == spi_csn_i[0] && synth_csn_o == spi_csn_i[1])
    else begin
      err_cnt++;
      $display("[FAIL] %s cs_pass expected %b actual %b",
               cur_test, $sampled(spi_csn_i), {$sampled(synth_csn_o), $sampled(conv_csn_o)});
    end

  // ************************************************
  // Host and device models
  // ************************************************

  // Galois form of x^32 + x^22 + x^2 + x + 1, shifting right
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  task automatic draw_bit(output logic b);
    lfsr_q = lfsr_step(lfsr_q);
    b      = lfsr_q[0];
  endtask

  // Inputs move 10 ns after the rising edge
  task automatic tick();
    @(posedge clk_i);
    #10;
  endtask

  // Device side of the turnaround, gives up after one SCLK half period
  task automatic wait_release(output int used);
    used = 0;
    while (sdio_oe_o && (used < HALF_CLKS)) begin
      tick();
      used++;
    end
    if (sdio_oe_o) begin
      err_cnt++;
      $display("%s: the bridge never released the data pin for the read", cur_test);
    end
  endtask

  // One SPI mode 0 frame, instruction first and then data_bits of data
  task automatic run_frame(input int cs_idx, input logic rw, input int data_bits);
    int   total;
    int   used;
    logic b;
    total         = int'(spi_bridge_proto_pkg::INSTR_BITS) + data_bits;
    rd_frame      = (cs_idx == 0) && rw;
    drive_frame   = !rd_frame;
    host_rise_cnt = 0;
    spi_mosi_i    = rw;
    spi_csn_i[cs_idx] = 1'b0;
    repeat (HALF_CLKS) tick();
    for (int i = 0; i < total; i++) begin
      spi_clk_i = 1'b1;
      host_rise_cnt++;
      repeat (HALF_CLKS) tick();
      spi_clk_i = 1'b0;
      used = 0;
      if (i + 1 < total) begin
        if (rd_frame && (i + 1 >= int'(spi_bridge_proto_pkg::INSTR_BITS))) begin
          // Read data phase, the device owns the pin once it is released
          spi_mosi_i = 1'b0;
          if (i + 1 == int'(spi_bridge_proto_pkg::INSTR_BITS)) begin
            rd_data_win = 1'b1;
            wait_release(used);
          end
          draw_bit(b);
          sdio_i = b;
        end else begin
          draw_bit(b);
          spi_mosi_i = b;
        end
      end
      repeat (HALF_CLKS - used) tick();
    end
    spi_csn_i   = '1;
    rd_data_win = 1'b0;
    sdio_i      = 1'b0;
    spi_mosi_i  = 1'b0;
    repeat (IDLE_CLKS) tick();
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = err_cnt;
  endtask

  task automatic finish_test();
    test_cnt++;
    $display("test %s done with %0d failed check(s)", cur_test, err_cnt - test_err_base);
  endtask

  // ************************************************
  // Test sequence
  // ************************************************

  initial begin
    rst_n_i     = 1'b0;
    spi_clk_i   = 1'b0;
    spi_csn_i   = '1;
    spi_mosi_i  = 1'b0;
    sdio_i      = 1'b0;
    rd_frame    = 1'b0;
    drive_frame = 1'b0;
    rd_data_win = 1'b0;
    host_rise_cnt = 0;
    lfsr_q      = 32'h9cb9;
    err_cnt     = 0;
    test_cnt    = 0;
    start_test("reset_state");
    repeat (2) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;
    repeat (4) tick();
    finish_test();

    start_test("conv_write");
    run_frame(0, 1'b0, 8);
    finish_test();

    start_test("conv_read");
    run_frame(0, 1'b1, 8);
    finish_test();

    start_test("synth_read_bit");
    run_frame(1, 1'b1, 8);
    finish_test();

    // The read stops after three data bits, then a write must still work
    start_test("read_abort");
    run_frame(0, 1'b1, 3);
    run_frame(0, 1'b0, 8);
    finish_test();

    start_test("cs_passthrough");
    run_frame(1, 1'b0, 8);
    run_frame(0, 1'b1, 8);
    finish_test();

    $display("%0d tests run, %0d checks failed", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Hard limit on the whole run
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: the simulation ran past its time limit");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- spi_bridge_top.sv
// ************************************************
// SPI bridge top: master MOSI/MISO onto the 3-wire pin
// ************************************************

`timescale 1ns/10ps
`default_nettype none

module spi_bridge_top (
  input  wire                                   clk_i,
  input  wire                                   rst_n_i,
  input  wire                                   spi_clk_i,
  input  wire  [spi_bridge_cfg_pkg::NUM_CS-1:0] spi_csn_i,
  input  wire                                   spi_mosi_i,
  input  wire                                   sdio_i,
  output logic                                  spi_miso_o,
  output logic                                  sdio_o,
  output logic                                  sdio_oe_o,
  output logic                                  conv_csn_o,
  output logic                                  synth_csn_o
);

  // Internal signals
  logic                               sclk_rise;
  logic                               sclk_fall;
  logic                               cs_start;
  logic                               cs_end;
  logic                               mosi_s;
  logic                               sdio_s;
  logic                               instr_done;
  logic                               rd_active;
  spi_bridge_proto_pkg::dev_sel_e     dev_sel;
  spi_bridge_proto_pkg::frame_phase_e phase;

  // The devices see the master's selects untouched
  assign conv_csn_o  = spi_csn_i[0];
  assign synth_csn_o = spi_csn_i[1];

  // ************************************************
  // Instances
  // ************************************************

  spi_edge_sync i_edge_sync (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .spi_clk_i   (spi_clk_i),
    .spi_csn_i   (spi_csn_i),
    .spi_mosi_i  (spi_mosi_i),
    .sdio_i      (sdio_i),
    .sclk_rise_o (sclk_rise),
    .sclk_fall_o (sclk_fall),
    .cs_start_o  (cs_start),
    .cs_end_o    (cs_end),
    .mosi_s_o    (mosi_s),
    .sdio_s_o    (sdio_s),
    .dev_sel_o   (dev_sel));

  spi_bit_counter i_bit_counter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .sclk_rise_i  (sclk_rise),
    .sclk_fall_i  (sclk_fall),
    .cs_start_i   (cs_start),
    .instr_done_o (instr_done));

  spi_dir_fsm i_dir_fsm (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cs_start_i   (cs_start),
    .cs_end_i     (cs_end),
    .sclk_rise_i  (sclk_rise),
    .mosi_s_i     (mosi_s),
    .instr_done_i (instr_done),
    .dev_sel_i    (dev_sel),
    .phase_o      (phase),
    .rd_active_o  (rd_active));

  spi_sdio_ctrl i_sdio_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rd_active_i (rd_active),
    .mosi_s_i    (mosi_s),
    .sdio_s_i    (sdio_s),
    .sdio_o      (sdio_o),
    .sdio_oe_o   (sdio_oe_o),
    .spi_miso_o  (spi_miso_o));

  // A read phase lives inside a converter frame and trails its select pin
  // by four cycles of synchronizer, edge register and FSM
  pin_owned_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (phase == spi_bridge_proto_pkg::PH_READ) |-> !$past(conv_csn_o, 4));

endmodule

`default_nettype wire

//--- spi_sdio_ctrl.sv
// ************************************************
// Data pin driver and enable, read data gate onto MISO
// ************************************************

`timescale 1ns/10ps
`default_nettype none

module spi_sdio_ctrl (
  input  wire  clk_i,
  input  wire  rst_n_i,
  input  wire  rd_active_i,
  input  wire  mosi_s_i,
  input  wire  sdio_s_i,
  output logic sdio_o,
  output logic sdio_oe_o,
  output logic spi_miso_o
);

  logic oe_q;

  // ************************************************
  // Pin enable
  // ************************************************

  // The bridge owns the pin outside of reads, so the enable comes up high
  // It lets go one cycle after a read starts and takes the pin back one
  // cycle after the read ends
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      oe_q <= 1'b1;
    end else begin
      oe_q <= ~rd_active_i;
    end
  end

  assign sdio_oe_o = oe_q;

  // Write data goes straight from the synchronized MOSI onto the pin
  assign sdio_o = mosi_s_i;

  // ************************************************
  // Read data return
  // ************************************************

  // The sampled pin goes to MISO only during a read
  assign spi_miso_o = rd_active_i & sdio_s_i;

  // MISO stays low for as long as the bridge drives the pin
  miso_quiet_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sdio_oe_o |-> !spi_miso_o);

endmodule

`default_nettype wire

//--- spi_dir_fsm.sv
// ************************************************
// Frame phase FSM, decides the data pin direction
// ************************************************

`timescale 1ns/10ps
`default_nettype none

module spi_dir_fsm (
  input  wire                                 clk_i,
  input  wire                                 rst_n_i,
  input  wire                                 cs_start_i,
  input  wire                                 cs_end_i,
  input  wire                                 sclk_rise_i,
  input  wire                                 mosi_s_i,
  input  wire                                 instr_done_i,
  input  var spi_bridge_proto_pkg::dev_sel_e  dev_sel_i,
  output spi_bridge_proto_pkg::frame_phase_e  phase_o,
  output logic                                rd_active_o
);

  spi_bridge_proto_pkg::frame_phase_e phase_q;
  spi_bridge_proto_pkg::frame_phase_e phase_d;
  logic                               rw_bit_q;
  logic                               rw_taken_q;
  logic                               conv_read;

  // Only the converter can answer a read; synthesizer frames stay in write
  assign conv_read = rw_bit_q && (dev_sel_i == spi_bridge_proto_pkg::DEV_CONV);

  // ************************************************
  // Next phase
  // ************************************************

  always_comb begin
    phase_d = phase_q;
    case (phase_q)
      spi_bridge_proto_pkg::PH_IDLE: begin
        if (cs_start_i) begin
          phase_d = spi_bridge_proto_pkg::PH_INSTR;
        end
      end
      spi_bridge_proto_pkg::PH_INSTR: begin
        if (instr_done_i) begin
          phase_d = conv_read ? spi_bridge_proto_pkg::PH_READ
                              : spi_bridge_proto_pkg::PH_WRITE;
        end
      end
      default: begin
        // Data phases run until the select goes high
        phase_d = phase_q;
      end
    endcase
    // Chip select release aborts any phase, a read included
    if (cs_end_i) begin
      phase_d = spi_bridge_proto_pkg::PH_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q <= spi_bridge_proto_pkg::PH_IDLE;
    end else begin
      phase_q <= phase_d;
    end
  end

  // ************************************************
  // Read/write bit capture
  // ************************************************

  // The first rising edge of the instruction carries the read/write bit
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rw_bit_q   <= 1'b0;
      rw_taken_q <= 1'b0;
    end else if (cs_start_i) begin
      rw_bit_q   <= 1'b0;
      rw_taken_q <= 1'b0;
    end else if (sclk_rise_i && !rw_taken_q &&
                 (phase_q == spi_bridge_proto_pkg::PH_INSTR)) begin
      rw_bit_q   <= mosi_s_i;
      rw_taken_q <= 1'b1;
    end
  end

  assign phase_o     = phase_q;
  assign rd_active_o = (phase_q == spi_bridge_proto_pkg::PH_READ);

  // The device select from the edge block must still be the converter here
  rd_conv_only_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_active_o |-> (dev_sel_i == spi_bridge_proto_pkg::DEV_CONV));

endmodule

`default_nettype wire

//--- spi_bit_counter.sv
// ************************************************
// SCLK rising edge counter, flags the instruction end
// ************************************************

`timescale 1ns/10ps
`default_nettype none

module spi_bit_counter (
  input  wire  clk_i,
  input  wire  rst_n_i,
  input  wire  sclk_rise_i,
  input  wire  sclk_fall_i,
  input  wire  cs_start_i,
  output logic instr_done_o
);

  spi_bridge_cfg_pkg::bit_cnt_t cnt_q;
  logic                         armed_q;
  logic                         last_instr_rise;
  logic                         done_seen_q;

  // The rise that brings the count to INSTR_BITS is the last instruction bit
  assign last_instr_rise = sclk_rise_i &&
    (cnt_q == spi_bridge_cfg_pkg::bit_cnt_t'(spi_bridge_proto_pkg::INSTR_BITS - 1));

  // ************************************************
  // Rising edge count
  // ************************************************

  // Counts from frame start and holds at all ones on long frames
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (cs_start_i) begin
      cnt_q <= '0;
    end else if (sclk_rise_i && (cnt_q != '1)) begin
      cnt_q <= cnt_q + spi_bridge_cfg_pkg::bit_cnt_t'(1);
    end
  end

  // ************************************************
  // Instruction end flag
  // ************************************************

  // Armed after the last instruction bit is sampled
  // The pulse goes out on the following SCLK fall, which gives the device
  // the second half of that bit to turn the pin around
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      armed_q      <= 1'b0;
      instr_done_o <= 1'b0;
    end else begin
      instr_done_o <= 1'b0;
      if (cs_start_i) begin
        armed_q <= 1'b0;
      end else if (last_instr_rise) begin
        armed_q <= 1'b1;
      end else if (armed_q && sclk_fall_i) begin
        armed_q      <= 1'b0;
        instr_done_o <= 1'b1;
      end
    end
  end

  // Remembers that this frame has already flagged its instruction end
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_seen_q <= 1'b0;
    end else if (cs_start_i) begin
      done_seen_q <= 1'b0;
    end else if (instr_done_o) begin
      done_seen_q <= 1'b1;
    end
  end

  // Arming happens only on the step into INSTR_BITS and the count saturates,
  // so a frame sees one pulse at most
  instr_once_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_done_o |-> !done_seen_q);

endmodule

`default_nettype wire

//--- spi_edge_sync.sv
// ************************************************
// SPI pin synchronizer with SCLK and frame edge detection
// ************************************************

`timescale 1ns/10ps
`default_nettype none

module spi_edge_sync (
  input  wire                                   clk_i,
  input  wire                                   rst_n_i,
  input  wire                                   spi_clk_i,
  input  wire  [spi_bridge_cfg_pkg::NUM_CS-1:0] spi_csn_i,
  input  wire                                   spi_mosi_i,
  input  wire                                   sdio_i,
  output logic                                  sclk_rise_o,
  output logic                                  sclk_fall_o,
  output logic                                  cs_start_o,
  output logic                                  cs_end_o,
  output logic                                  mosi_s_o,
  output logic                                  sdio_s_o,
  output spi_bridge_proto_pkg::dev_sel_e        dev_sel_o
);

  // All pins share one chain, laid out as {sclk, csn, mosi, sdio}
  logic [spi_bridge_cfg_pkg::NUM_CS+2:0] pin_vec;
  logic [spi_bridge_cfg_pkg::NUM_CS+2:0] sync_q [spi_bridge_cfg_pkg::SYNC_STAGES];
  logic [spi_bridge_cfg_pkg::NUM_CS+2:0] sync_vec;
  logic [spi_bridge_cfg_pkg::NUM_CS-1:0] csn_s;
  logic                                  sclk_s;
  logic                                  cs_low_s;
  logic                                  sclk_d_q;
  logic                                  cs_low_d_q;
  logic                                  frame_open;

  // ************************************************
  // Synchronizer chains
  // ************************************************

  assign pin_vec = {spi_clk_i, spi_csn_i, spi_mosi_i, sdio_i};

  // Reset puts every chain at the idle bus level: SCLK low, selects high
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < spi_bridge_cfg_pkg::SYNC_STAGES; i++) begin
        sync_q[i] <= {1'b0, {spi_bridge_cfg_pkg::NUM_CS{1'b1}}, 2'b00};
      end
    end else begin
      sync_q[0] <= pin_vec;
      for (int i = 1; i < spi_bridge_cfg_pkg::SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign sync_vec = sync_q[spi_bridge_cfg_pkg::SYNC_STAGES-1];
  assign sclk_s   = sync_vec[spi_bridge_cfg_pkg::NUM_CS+2];
  assign csn_s    = sync_vec[spi_bridge_cfg_pkg::NUM_CS+1:2];
  assign mosi_s_o = sync_vec[1];
  assign sdio_s_o = sync_vec[0];

  // A frame is open while any select is low
  assign cs_low_s   = ~&csn_s;
  assign frame_open = cs_low_s & ~cs_low_d_q;

  // ************************************************
  // Edge registers
  // ************************************************

  // Pulses are registered, so they trail the pin by one cycle more than the levels
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sclk_d_q    <= 1'b0;
      cs_low_d_q  <= 1'b0;
      sclk_rise_o <= 1'b0;
      sclk_fall_o <= 1'b0;
      cs_start_o  <= 1'b0;
      cs_end_o    <= 1'b0;
      dev_sel_o   <= spi_bridge_proto_pkg::DEV_CONV;
    end else begin
      sclk_d_q    <= sclk_s;
      cs_low_d_q  <= cs_low_s;
      sclk_rise_o <= sclk_s & ~sclk_d_q;
      sclk_fall_o <= ~sclk_s & sclk_d_q;
      cs_start_o  <= frame_open;
      cs_end_o    <= ~cs_low_s & cs_low_d_q;
      // The device is fixed for the whole frame from the select that opened it
      if (frame_open) begin
        dev_sel_o <= csn_s[0] ? spi_bridge_proto_pkg::DEV_SYNTH
                              : spi_bridge_proto_pkg::DEV_CONV;
      end
    end
  end

  // The master serializes frames, so at most one device is ever selected
  cs_one_low_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $countones(csn_s) >= (spi_bridge_cfg_pkg::NUM_CS - 1));

endmodule

`default_nettype wire

//--- spi_bridge_cfg_pkg.sv
// ************************************************
// SPI bridge timing and configuration constants
// ************************************************

`default_nettype none

package spi_bridge_cfg_pkg;

  // Flops per synchronizer chain on every SPI pin
  localparam int unsigned SYNC_STAGES = 2;

  // Chip selects driven by the SPI master
  // Bit 0 is the converter and bit 1 the synthesizer
  localparam int unsigned NUM_CS = 2;

  // Width of the SCLK edge counter
  // Six bits hold the instruction and a data word with room to saturate
  localparam int unsigned BIT_CNT_W = 6;

  // Counter type so that constants can be cast to the counter width
  typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

endpackage

`default_nettype wire

//--- spi_bridge_proto_pkg.sv
// ************************************************
// SPI bridge frame format: frame phases, device
// select codes and the converter instruction length
// ************************************************

`default_nettype none

package spi_bridge_proto_pkg;

  // ************************************************
  // Frame phases
  // ************************************************

  // Every converter frame is an instruction followed by a data phase
  // PH_WRITE and PH_READ tell the data phase direction once the instruction is over
  typedef enum logic [1:0] {
    PH_IDLE  = 2'd0,
    PH_INSTR = 2'd1,
    PH_WRITE = 2'd2,
    PH_READ  = 2'd3
  } frame_phase_e;

  // ************************************************
  // Devices on the shared SPI master
  // ************************************************

  // The converter sits on chip select 0 and has the 3-wire data pin
  // The synthesizer on chip select 1 only ever takes data
  typedef enum logic {
    DEV_CONV  = 1'b0,
    DEV_SYNTH = 1'b1
  } dev_sel_e;

  // Instruction length in SCLK bits, read/write bit first
  localparam int unsigned INSTR_BITS = 16;

endpackage

`default_nettype wire
